// File: Makefile
TOP = mipsLiteTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f mipsLite.f --top-module $(TOP)

sim:
	verilator --binary --timing -f mipsLite.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | awk '{ print } /TEST RESULT: PASS/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// File: mipsLite.f
+incdir+source
source/mipsPkg.sv
source/controlBus.sv
source/decoder.sv
source/fetchUnit.sv
source/regFile.sv
source/alu.sv
source/datapath.sv
source/dataMemory.sv
source/mipsLite.sv
verif/clockGen.sv
verif/mipsLiteTb.sv

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsLite_defines.svh"

module alu (
	input mipsPkg::aluOpT aluOp,
	input wire logic [`WORD_WIDTH-1:0] operandA,
	input wire logic [`WORD_WIDTH-1:0] operandB,
	output logic [`WORD_WIDTH-1:0] result,
	output logic takeBranch
);
	import mipsPkg::*;

	logic aIsZero;
	logic aIsNeg;

	assign aIsZero = (operandA == '0);
	assign aIsNeg = operandA[`WORD_WIDTH-1];

	always_comb begin
		case (aluOp)
			ALU_ADD: result = operandA + operandB;
			ALU_SUB: result = operandA - operandB;
			ALU_AND: result = operandA & operandB;
			ALU_OR: result = operandA | operandB;
			ALU_XOR: result = operandA ^ operandB;
			ALU_NOR: result = ~(operandA | operandB);
			ALU_SLT: result = `WORD_WIDTH'($signed(operandA) < $signed(operandB));
			ALU_SLTU: result = `WORD_WIDTH'(operandA < operandB);
			ALU_LUI: result = {operandB[15:0], 16'b0};
			default: result = operandA; // pass and branch ops
		endcase
	end

	always_comb begin
		case (aluOp)
			ALU_BEQ: takeBranch = (operandA == operandB);
			ALU_BNE: takeBranch = (operandA != operandB);
			ALU_BLEZ: takeBranch = aIsNeg || aIsZero;
			ALU_BGTZ: takeBranch = !aIsNeg && !aIsZero;
			ALU_BLTZ: takeBranch = aIsNeg;
			ALU_BGEZ: takeBranch = !aIsNeg;
			default: takeBranch = 1'b0;
		endcase
	end
endmodule

`default_nettype wire

// File: source/controlBus.sv
`timescale 1ns/1ps
`default_nettype none

interface controlBus;
	import mipsPkg::*;

	logic regDst; // rd instead of rt
	logic aluSrc; // immediate as operand b
	logic zeroExtend;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic memToReg;
	logic branch;
	logic jump;
	logic jumpReg;
	logic link;
	aluOpT aluOp;

	modport decoder (output regDst, aluSrc, zeroExtend, regWrite, memRead, memWrite,
		memToReg, branch, jump, jumpReg, link, aluOp);
	modport datapath (input regDst, aluSrc, zeroExtend, regWrite, memRead, memWrite,
		memToReg, link, aluOp);
	modport fetch (input branch, jump, jumpReg);
endinterface

`default_nettype wire

// File: source/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsLite_defines.svh"

module dataMemory (
	input wire logic clock,
	input wire logic reset,
	input wire logic [`WORD_WIDTH-1:0] address,
	input wire logic [`WORD_WIDTH-1:0] writeData,
	input wire logic memRead,
	input wire logic memWrite,
	output logic [`WORD_WIDTH-1:0] readData,
	output logic [`WORD_WIDTH-1:0] serialData,
	output logic serialWrite
);
	localparam int dmemAddrWidth = $clog2(`DMEM_DEPTH);

	logic [`WORD_WIDTH-1:0] ram [`DMEM_DEPTH];
	logic [dmemAddrWidth-1:0] wordIndex;
	logic isSerial;

	assign wordIndex = address[dmemAddrWidth+1:2];
	assign isSerial = (address == `SERIAL_ADDR);

	always_ff @(posedge clock) begin
		if (memWrite && !isSerial)
			ram[wordIndex] <= writeData;
		if (memWrite && isSerial)
			serialData <= writeData; // held until next serial store
	end

	always_ff @(posedge clock) begin
		if (reset)
			serialWrite <= 1'b0;
		else
			serialWrite <= memWrite && isSerial; // one cycle pulse
	end

	assign readData = memRead ? ram[wordIndex] : '0;
endmodule

`default_nettype wire

// File: source/datapath.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsLite_defines.svh"

module datapath (
	input wire logic clock,
	input wire logic reset,
	input wire logic [`WORD_WIDTH-1:0] instruction,
	input wire logic [`WORD_WIDTH-1:0] pcPlus4,
	input wire logic [`WORD_WIDTH-1:0] loadData,
	controlBus.datapath ctrl,
	output logic [`WORD_WIDTH-1:0] rsValue,
	output logic takeBranch,
	output logic [`WORD_WIDTH-1:0] memAddress,
	output logic [`WORD_WIDTH-1:0] storeData
);
	logic [`WORD_WIDTH-1:0] rtValue;
	logic [`WORD_WIDTH-1:0] immediate;
	logic [`WORD_WIDTH-1:0] operandB;
	logic [`WORD_WIDTH-1:0] aluResult;
	logic [`WORD_WIDTH-1:0] writeData;
	logic [`REG_ADDR_WIDTH-1:0] writeReg;

	assign immediate = ctrl.zeroExtend ? {{(`WORD_WIDTH-16){1'b0}}, instruction[15:0]}
		: {{(`WORD_WIDTH-16){instruction[15]}}, instruction[15:0]};
	assign operandB = ctrl.aluSrc ? immediate : rtValue;

	// jal links to r31, jalr to rd
	assign writeReg = (ctrl.link && !ctrl.regDst) ? `LINK_REG
		: ctrl.regDst ? instruction[15:11] : instruction[20:16];

	assign writeData = ctrl.link ? pcPlus4 : ctrl.memToReg ? loadData : aluResult;

	regFile registers (
		.clock(clock),
		.reset(reset),
		.readAddressA(instruction[25:21]),
		.readAddressB(instruction[20:16]),
		.writeAddress(writeReg),
		.writeData(writeData),
		.writeEnable(ctrl.regWrite),
		.readDataA(rsValue),
		.readDataB(rtValue)
	);

	alu aluUnit (
		.aluOp(ctrl.aluOp),
		.operandA(rsValue),
		.operandB(operandB),
		.result(aluResult),
		.takeBranch(takeBranch)
	);

	assign memAddress = aluResult;
	assign storeData = rtValue;
endmodule

`default_nettype wire

// File: source/decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsLite_defines.svh"

module decoder (
	input wire logic [`WORD_WIDTH-1:0] instruction,
	controlBus.decoder ctrl
);
	import mipsPkg::*;

	opcodeT opcode;
	functT funct;
	aluOpT rOp;

	assign opcode = opcodeT'(instruction[31:26]);
	assign funct = functT'(instruction[5:0]);

	always_comb begin
		case (funct)
			FN_ADD, FN_ADDU: rOp = ALU_ADD;
			FN_SUB, FN_SUBU: rOp = ALU_SUB;
			FN_AND: rOp = ALU_AND;
			FN_OR: rOp = ALU_OR;
			FN_XOR: rOp = ALU_XOR;
			FN_NOR: rOp = ALU_NOR;
			FN_SLT: rOp = ALU_SLT;
			FN_SLTU: rOp = ALU_SLTU;
			default: rOp = ALU_PASS; // jr, jalr and unknowns
		endcase
	end

	always_comb begin
		ctrl.regDst = 1'b0;
		ctrl.aluSrc = 1'b0;
		ctrl.zeroExtend = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.memToReg = 1'b0;
		ctrl.branch = 1'b0;
		ctrl.jump = 1'b0;
		ctrl.jumpReg = 1'b0;
		ctrl.link = 1'b0;
		ctrl.aluOp = ALU_PASS;
		case (opcode)
			OP_SPECIAL: begin
				if (rOp != ALU_PASS) begin
					ctrl.aluOp = rOp;
					ctrl.regDst = 1'b1;
					ctrl.regWrite = 1'b1;
				end else if (funct == FN_JR) begin
					ctrl.jumpReg = 1'b1;
				end else if (funct == FN_JALR) begin
					ctrl.jumpReg = 1'b1;
					ctrl.link = 1'b1;
					ctrl.regDst = 1'b1; // link goes to rd
					ctrl.regWrite = 1'b1;
				end
			end
			OP_REGIMM: begin
				if (instruction[20:16] == 5'd0) begin
					ctrl.branch = 1'b1;
					ctrl.aluOp = ALU_BLTZ;
				end else if (instruction[20:16] == 5'd1) begin
					ctrl.branch = 1'b1;
					ctrl.aluOp = ALU_BGEZ;
				end
			end
			OP_J: ctrl.jump = 1'b1;
			OP_JAL: begin
				ctrl.jump = 1'b1;
				ctrl.link = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
				ctrl.branch = 1'b1;
				ctrl.aluOp = (opcode == OP_BEQ) ? ALU_BEQ :
					(opcode == OP_BNE) ? ALU_BNE :
					(opcode == OP_BLEZ) ? ALU_BLEZ : ALU_BGTZ;
			end
			OP_ADDI, OP_ADDIU, OP_LUI, OP_LW: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = (opcode == OP_LUI) ? ALU_LUI : ALU_ADD;
				ctrl.memRead = (opcode == OP_LW);
				ctrl.memToReg = (opcode == OP_LW);
			end
			OP_ANDI, OP_ORI, OP_XORI: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.zeroExtend = 1'b1;
				ctrl.aluOp = (opcode == OP_ANDI) ? ALU_AND :
					(opcode == OP_ORI) ? ALU_OR : ALU_XOR;
			end
			OP_SW: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.aluOp = ALU_ADD;
			end
			default: ; // unknown opcode runs as nop
		endcase
	end
endmodule

`default_nettype wire

// File: source/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsLite_defines.svh"

module fetchUnit (
	input wire logic clock,
	input wire logic reset,
	input wire logic progWrite,
	input wire logic [$clog2(`IMEM_DEPTH)-1:0] progAddress,
	input wire logic [`WORD_WIDTH-1:0] progData,
	input wire logic [`WORD_WIDTH-1:0] rsValue,
	input wire logic takeBranch,
	controlBus.fetch ctrl,
	output logic [`WORD_WIDTH-1:0] instruction,
	output logic [`WORD_WIDTH-1:0] pcPlus4
);
	localparam int imemAddrWidth = $clog2(`IMEM_DEPTH);

	logic [`WORD_WIDTH-1:0] pc;
	logic [`WORD_WIDTH-1:0] pcOffset;
	logic [`WORD_WIDTH-1:0] nextPc;
	logic [`WORD_WIDTH-1:0] branchTarget;
	logic [`WORD_WIDTH-1:0] jumpTarget;
	logic [`WORD_WIDTH-1:0] imem [`IMEM_DEPTH];

	always_ff @(posedge clock) begin
		if (progWrite)
			imem[progAddress] <= progData; // loader writes while core is in reset
	end

	assign pcOffset = pc - `RESET_PC;
	assign instruction = imem[pcOffset[imemAddrWidth+1:2]];
	assign pcPlus4 = pc + `WORD_WIDTH'(4);

	assign branchTarget = pcPlus4 + {{(`WORD_WIDTH-18){instruction[15]}}, instruction[15:0], 2'b00};
	assign jumpTarget = {pcPlus4[`WORD_WIDTH-1:28], instruction[25:0], 2'b00};

	always_comb begin
		if (ctrl.jumpReg)
			nextPc = rsValue;
		else if (ctrl.jump)
			nextPc = jumpTarget;
		else if (ctrl.branch && takeBranch)
			nextPc = branchTarget;
		else
			nextPc = pcPlus4;
	end

	always_ff @(posedge clock) begin
		if (reset)
			pc <= `RESET_PC;
		else
			pc <= nextPc;
	end
endmodule

`default_nettype wire

// File: source/mipsLite.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsLite_defines.svh"

module mipsLite (
	input wire logic clock,
	input wire logic reset,
	input wire logic progWrite,
	input wire logic [5:0] progAddress,
	input wire logic [`WORD_WIDTH-1:0] progData,
	output logic [`WORD_WIDTH-1:0] serialData,
	output logic serialWrite
);
	logic [`WORD_WIDTH-1:0] instruction;
	logic [`WORD_WIDTH-1:0] pcPlus4;
	logic [`WORD_WIDTH-1:0] rsValue;
	logic takeBranch;
	logic [`WORD_WIDTH-1:0] memAddress;
	logic [`WORD_WIDTH-1:0] storeData;
	logic [`WORD_WIDTH-1:0] loadData;

	controlBus ctrl ();

	fetchUnit fetch (
		.clock(clock),
		.reset(reset),
		.progWrite(progWrite),
		.progAddress(progAddress),
		.progData(progData),
		.rsValue(rsValue),
		.takeBranch(takeBranch),
		.ctrl(ctrl.fetch),
		.instruction(instruction),
		.pcPlus4(pcPlus4)
	);

	decoder decode (
		.instruction(instruction),
		.ctrl(ctrl.decoder)
	);

	datapath dp (
		.clock(clock),
		.reset(reset),
		.instruction(instruction),
		.pcPlus4(pcPlus4),
		.loadData(loadData),
		.ctrl(ctrl.datapath),
		.rsValue(rsValue),
		.takeBranch(takeBranch),
		.memAddress(memAddress),
		.storeData(storeData)
	);

	dataMemory dmem (
		.clock(clock),
		.reset(reset),
		.address(memAddress),
		.writeData(storeData),
		.memRead(ctrl.memRead),
		.memWrite(ctrl.memWrite),
		.readData(loadData),
		.serialData(serialData),
		.serialWrite(serialWrite)
	);
endmodule

`default_nettype wire

// File: source/mipsLite_defines.svh
`ifndef MIPSLITE_DEFINES_SVH
`define MIPSLITE_DEFINES_SVH

// data path and address width
`define WORD_WIDTH 32

`define REG_ADDR_WIDTH 5

// first fetch after reset
`define RESET_PC 32'h0040_0000

`define IMEM_DEPTH 64

`define DMEM_DEPTH 64

// stores here go out the serial port instead of RAM
`define SERIAL_ADDR 32'hFFFF_0000

`define LINK_REG 5'd31

`endif

// File: source/mipsPkg.sv
`default_nettype none

package mipsPkg;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_REGIMM  = 6'h01,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_BLEZ    = 6'h06,
		OP_BGTZ    = 6'h07,
		OP_ADDI    = 6'h08,
		OP_ADDIU   = 6'h09,
		OP_ANDI    = 6'h0C,
		OP_ORI     = 6'h0D,
		OP_XORI    = 6'h0E,
		OP_LUI     = 6'h0F,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2B
	} opcodeT;

	typedef enum logic [5:0] {
		FN_JR   = 6'h08,
		FN_JALR = 6'h09,
		FN_ADD  = 6'h20,
		FN_ADDU = 6'h21,
		FN_SUB  = 6'h22,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2A,
		FN_SLTU = 6'h2B
	} functT;

	// pass is zero so an all-low decode is a no-op
	typedef enum logic [3:0] {
		ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND,
		ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
		ALU_SLTU, ALU_LUI, ALU_BEQ, ALU_BNE,
		ALU_BLEZ, ALU_BGTZ, ALU_BLTZ, ALU_BGEZ
	} aluOpT;

endpackage

`default_nettype wire

// File: source/regFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsLite_defines.svh"

module regFile (
	input wire logic clock,
	input wire logic reset,
	input wire logic [`REG_ADDR_WIDTH-1:0] readAddressA,
	input wire logic [`REG_ADDR_WIDTH-1:0] readAddressB,
	input wire logic [`REG_ADDR_WIDTH-1:0] writeAddress,
	input wire logic [`WORD_WIDTH-1:0] writeData,
	input wire logic writeEnable,
	output logic [`WORD_WIDTH-1:0] readDataA,
	output logic [`WORD_WIDTH-1:0] readDataB
);
	localparam int numRegs = 1 << `REG_ADDR_WIDTH;

	logic [`WORD_WIDTH-1:0] regs [numRegs];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < numRegs; i++)
				regs[i] <= '0;
		end else if (writeEnable && writeAddress != '0) begin
			regs[writeAddress] <= writeData;
		end
	end

	// r0 is hardwired to zero
	assign readDataA = (readAddressA == '0) ? '0 : regs[readAddressA];
	assign readDataB = (readAddressB == '0) ? '0 : regs[readAddressB];
endmodule

`default_nettype wire

// File: verif/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clock
);
	initial clock = 1'b0;

	always #50 clock = ~clock; // 100 ns period
endmodule

`default_nettype wire

// File: verif/mipsLiteTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsLite_defines.svh"

module mipsLiteTb;
	import mipsPkg::*;

	localparam int timeoutCycles = 6 * (64 + 200);
	localparam logic [15:0] fallMarker = 16'hFA11;

	logic clock;
	logic reset;
	logic progWrite;
	logic [5:0] progAddress;
	logic [31:0] progData;
	logic [31:0] serialData;
	logic serialWrite;

	logic [31:0] progQ[$];
	logic [31:0] expQ[$];
	logic [31:0] gotQ[$];
	time timeQ[$];
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;

	clockGen clockSource (.clock(clock));

	mipsLite UUT (
		.clock(clock),
		.reset(reset),
		.progWrite(progWrite),
		.progAddress(progAddress),
		.progData(progData),
		.serialData(serialData),
		.serialWrite(serialWrite)
	);

	function automatic logic [31:0] rType(input int rs, input int rt, input int rd,
		input logic [5:0] fn);
		return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, fn};
	endfunction

	function automatic logic [31:0] iType(input logic [5:0] op, input int rs, input int rt,
		input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] addrOf(input int idx);
		return `RESET_PC + 32'(4 * idx);
	endfunction

	function automatic logic [31:0] jType(input logic [5:0] op, input int idx);
		logic [31:0] target;
		target = addrOf(idx);
		return {op, target[27:2]};
	endfunction

	function automatic logic [31:0] modelR(input logic [5:0] fn, input logic [31:0] a,
		input logic [31:0] b);
		case (fn)
			FN_ADD, FN_ADDU: return a + b;
			FN_SUB, FN_SUBU: return a - b;
			FN_AND: return a & b;
			FN_OR: return a | b;
			FN_XOR: return a ^ b;
			FN_NOR: return ~(a | b);
			FN_SLT: return {31'h0, $signed(a) < $signed(b)};
			FN_SLTU: return {31'h0, a < b};
			default: return 32'h0;
		endcase
	endfunction

	function automatic logic [31:0] modelI(input logic [5:0] op, input logic [31:0] a,
		input logic [15:0] imm);
		logic [31:0] sext;
		logic [31:0] zext;
		sext = {{16{imm[15]}}, imm};
		zext = {16'h0, imm};
		case (op)
			OP_ADDI, OP_ADDIU: return a + sext;
			OP_ANDI: return a & zext; // logic immediates zero extend
			OP_ORI: return a | zext;
			OP_XORI: return a ^ zext;
			OP_LUI: return {imm, 16'h0};
			default: return 32'h0;
		endcase
	endfunction

	function automatic bit branchModel(input logic [5:0] op, input int rtField,
		input logic [31:0] a, input logic [31:0] b);
		case (op)
			OP_BEQ: return a == b;
			OP_BNE: return a != b;
			OP_BLEZ: return $signed(a) <= 0;
			OP_BGTZ: return $signed(a) > 0;
			OP_REGIMM: return (rtField == 0) ? ($signed(a) < 0) : ($signed(a) >= 0);
			default: return 1'b0;
		endcase
	endfunction

	task automatic loadConst(input int r, input logic [31:0] v);
		progQ.push_back(iType(OP_LUI, 0, r, v[31:16]));
		progQ.push_back(iType(OP_ORI, r, r, v[15:0]));
	endtask

	task automatic sendReg(input int r);
		progQ.push_back(iType(OP_SW, 30, r, 16'h0)); // r30 holds the serial address
	endtask

	task automatic startProgram();
		progQ.delete();
		expQ.delete();
		loadConst(30, `SERIAL_ADDR);
	endtask

	task automatic checkQuiet(input string name);
		checkCount++;
		if (serialWrite !== 1'b0) begin
			errorCount++;
			$display("Mismatch at %0t: serialWrite during reset in %s test: expected 0, got %b",
				$time, name, serialWrite);
		end
	endtask

	task automatic sampleSerial();
		@(posedge clock);
		if (serialWrite === 1'b1) begin
			gotQ.push_back(serialData);
			timeQ.push_back($time);
		end
	endtask

	task automatic compareSerial(input string name);
		checkCount++;
		if (gotQ.size() != expQ.size()) begin
			errorCount++;
			$display("%s test: expected %0d serial words within 200 cycles, got %0d",
				name, expQ.size(), gotQ.size());
		end
		for (int i = 0; i < expQ.size() && i < gotQ.size(); i++) begin
			checkCount++;
			if (gotQ[i] !== expQ[i]) begin
				errorCount++;
				$display("Mismatch at %0t: serialData word %0d of %s test: expected %h, got %h",
					timeQ[i], i, name, expQ[i], gotQ[i]);
			end
		end
	endtask

	// hold reset, load all words, release, then collect serial output
	task automatic runProgram(input string name, input int idleCycles);
		int waited;
		gotQ.delete();
		timeQ.delete();
		@(posedge clock);
		reset <= 1'b1;
		for (int i = 0; i < `IMEM_DEPTH; i++) begin
			@(posedge clock);
			if (i > 0)
				checkQuiet(name);
			progWrite <= 1'b1;
			progAddress <= 6'(i);
			progData <= (i < progQ.size()) ? progQ[i] : 32'h0; // pad with nops
		end
		@(posedge clock);
		checkQuiet(name);
		progWrite <= 1'b0;
		repeat (4) begin
			@(posedge clock);
			checkQuiet(name);
		end
		reset <= 1'b0;
		waited = 0;
		while (gotQ.size() < expQ.size() && waited < 200) begin
			sampleSerial();
			waited++;
		end
		repeat (idleCycles) sampleSerial(); // catch extra words
		compareSerial(name);
	endtask

	task automatic resetTest();
		progQ.delete();
		expQ.delete();
		runProgram("reset", 50);
	endtask

	task automatic aluTest();
		logic [31:0] a;
		logic [31:0] b;
		logic [15:0] imm;
		logic [5:0] fnList [10];
		logic [5:0] opList [6];
		a = $urandom() | 32'h8000_0000; // negative so slt and sltu differ
		b = $urandom() & 32'h7FFF_FFFF;
		imm = 16'($urandom()) | 16'h8000;
		fnList = '{FN_ADDU, FN_ADD, FN_SUBU, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_NOR,
			FN_SLT, FN_SLTU};
		opList = '{OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
		startProgram();
		loadConst(1, a);
		loadConst(2, b);
		foreach (fnList[i]) begin
			progQ.push_back(rType(1, 2, 3, fnList[i]));
			sendReg(3);
			expQ.push_back(modelR(fnList[i], a, b));
		end
		foreach (opList[i]) begin
			progQ.push_back(iType(opList[i], (opList[i] == OP_LUI) ? 0 : 1, 4, imm));
			sendReg(4);
			expQ.push_back(modelI(opList[i], a, imm));
		end
		progQ.push_back(rType(1, 2, 0, FN_ADDU)); // r0 must stay zero
		sendReg(0);
		expQ.push_back(32'h0);
		runProgram("ALU", 4);
	endtask

	task automatic memoryTest();
		logic [31:0] values [4];
		logic [15:0] offsets [4];
		int order [4];
		values = '{32'h1234_5678, 32'hDEAD_BEEF, 32'h0F0F_F0F0, 32'h8000_0001};
		offsets = '{16'h0000, 16'h0014, 16'h0028, 16'h00FC};
		order = '{2, 0, 3, 1};
		startProgram();
		for (int i = 0; i < 4; i++) begin
			loadConst(1, values[i]);
			progQ.push_back(iType(OP_SW, 0, 1, offsets[i]));
		end
		foreach (order[i]) begin
			progQ.push_back(iType(OP_LW, 0, 2, offsets[order[i]]));
			sendReg(2);
			expQ.push_back(values[order[i]]);
		end
		runProgram("load/store", 4);
	endtask

	// fall marker only shows up when the branch is not taken
	task automatic branchCase(input logic [5:0] op, input int rs, input int rt,
		input logic [31:0] a, input logic [31:0] b, input logic [15:0] id);
		progQ.push_back(iType(op, rs, rt, 16'd1));
		sendReg(11);
		progQ.push_back(iType(OP_ORI, 0, 5, id));
		sendReg(5);
		if (!branchModel(op, rt, a, b))
			expQ.push_back({16'h0, fallMarker});
		expQ.push_back({16'h0, id});
	endtask

	task automatic branchTest();
		logic [31:0] neg;
		neg = 32'hFFFF_FFFD;
		startProgram();
		progQ.push_back(iType(OP_ORI, 0, 11, fallMarker));
		progQ.push_back(iType(OP_ORI, 0, 1, 16'd5));
		progQ.push_back(iType(OP_ORI, 0, 2, 16'd5));
		progQ.push_back(iType(OP_ORI, 0, 3, 16'd7));
		progQ.push_back(iType(OP_ADDIU, 0, 4, neg[15:0])); // -3
		branchCase(OP_BEQ, 1, 2, 5, 5, 16'h0101);
		branchCase(OP_BEQ, 1, 3, 5, 7, 16'h0102);
		branchCase(OP_BNE, 1, 3, 5, 7, 16'h0201);
		branchCase(OP_BNE, 1, 2, 5, 5, 16'h0202);
		branchCase(OP_BLEZ, 4, 0, neg, 0, 16'h0301);
		branchCase(OP_BLEZ, 0, 0, 0, 0, 16'h0302);
		branchCase(OP_BLEZ, 1, 0, 5, 0, 16'h0303);
		branchCase(OP_BGTZ, 1, 0, 5, 0, 16'h0401);
		branchCase(OP_BGTZ, 0, 0, 0, 0, 16'h0402);
		branchCase(OP_REGIMM, 4, 0, neg, 0, 16'h0501); // bltz
		branchCase(OP_REGIMM, 0, 0, 0, 0, 16'h0502);
		branchCase(OP_REGIMM, 0, 1, 0, 0, 16'h0601); // bgez
		branchCase(OP_REGIMM, 4, 1, neg, 0, 16'h0602);
		runProgram("branch", 4);
	endtask

	task automatic jumpTest();
		startProgram();
		progQ.push_back(iType(OP_ORI, 0, 11, 16'h0BAD));
		progQ.push_back(jType(OP_J, 5));
		sendReg(11);
		progQ.push_back(jType(OP_JAL, 8)); // word 5
		progQ.push_back(jType(OP_J, 11)); // jr r31 lands here
		sendReg(11);
		sendReg(31);
		progQ.push_back(rType(31, 0, 0, FN_JR));
		sendReg(11);
		loadConst(14, addrOf(17)); // word 11
		progQ.push_back(rType(14, 0, 13, FN_JALR));
		progQ.push_back(iType(OP_ORI, 0, 5, 16'h0777)); // word 14
		sendReg(5);
		progQ.push_back(jType(OP_J, 20));
		sendReg(13); // word 17
		progQ.push_back(rType(13, 0, 0, FN_JR));
		sendReg(11);
		expQ.push_back(addrOf(6));
		expQ.push_back(addrOf(14));
		expQ.push_back(32'h0000_0777);
		runProgram("jump", 4);
	endtask

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout: run did not finish within %0d cycles", timeoutCycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		reset <= 1'b1;
		progWrite <= 1'b0;
		progAddress <= '0;
		progData <= '0;
		void'($urandom(82));
		resetTest();
		aluTest();
		memoryTest();
		branchTest();
		jumpTest();
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end
endmodule

`default_nettype wire
